// File: Bender.yml
package:
  name: l2_cache

sources:
  - src/l2_pkg.sv
  - src/l2_ifs.sv
  - src/l2_dir_issue.sv
  - src/l2_tag_way.sv
  - src/l2_way_select.sv
  - src/l2_cache_read.sv
  - src/l2_cache_write.sv
  - src/l2_cache_top.sv
  - target: test
    files:
      - bench/tb_clock_gen.sv
      - bench/tb_l2_cache.sv

// File: bench/tb_clock_gen.sv
// Clock and reset generator for the testbench

module tb_clock_gen #(
	parameter int PERIOD       = 10,
	parameter int RESET_CYCLES = 16
) (
	output logic clk,
	output logic arst_n
);

	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD / 2) clk = ~clk;
	end

	// Release away from the rising edge
	initial
	begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
	end

endmodule

// File: bench/tb_l2_cache.sv
// Testbench for the L2 cache request pipeline
// Reference model, response queue, compare tasks and watchdog

module tb_l2_cache;
	import l2_pkg::*;

	localparam int PERIOD       = 10;
	localparam int RESET_CYCLES = 16;
	localparam int NUM_DIRECTED = 13;
	localparam int NUM_RANDOM   = 200;
	localparam int NUM_REQ      = NUM_DIRECTED + NUM_RANDOM;
	localparam int NUM_SETS     = 2**SET_BITS;
	localparam int TIMEOUT      = (RESET_CYCLES + NUM_REQ * 8) * PERIOD;

	typedef struct packed
	{
		logic                 op;
		l2_addr_u             addr;
		logic                 hit;
		logic                 fill_needed;
		logic [LINE_BITS-1:0] data;
		logic                 wb_valid;
		l2_addr_u             wb_addr;
		logic [LINE_BITS-1:0] wb_data;
	} resp_t;

	logic                 clk;
	logic                 arst_n;
	logic                 req_valid;
	logic                 req_op;
	l2_addr_u             req_addr;
	logic [LINE_BITS-1:0] req_data;
	logic [MASK_BITS-1:0] req_mask;
	logic                 req_has_fill;
	logic [LINE_BITS-1:0] req_fill_data;
	logic                 resp_valid;
	logic                 resp_op;
	l2_addr_u             resp_addr;
	logic                 resp_hit;
	logic                 resp_fill_needed;
	logic [LINE_BITS-1:0] resp_data;
	logic                 wb_valid;
	l2_addr_u             wb_addr;
	logic [LINE_BITS-1:0] wb_data;

	// Model of the directory and line contents
	logic                 m_valid [NUM_SETS][NUM_WAYS];
	logic                 m_dirty [NUM_SETS][NUM_WAYS];
	logic [TAG_BITS-1:0]  m_tag   [NUM_SETS][NUM_WAYS];
	logic [LINE_BITS-1:0] m_line  [NUM_SETS][NUM_WAYS];

	resp_t exp_q [$];
	resp_t expected;
	int    sent_count = 0;
	int    seen_count = 0;
	int    slot = 0;
	int    last_slot [NUM_SETS];

	tb_clock_gen #(
		.PERIOD       (PERIOD),
		.RESET_CYCLES (RESET_CYCLES)
	) i_clock_gen (
		.clk    (clk),
		.arst_n (arst_n)
	);

	l2_cache_top i_dut (
		.clk              (clk),
		.arst_n           (arst_n),
		.req_valid        (req_valid),
		.req_op           (req_op),
		.req_addr         (req_addr),
		.req_data         (req_data),
		.req_mask         (req_mask),
		.req_has_fill     (req_has_fill),
		.req_fill_data    (req_fill_data),
		.resp_valid       (resp_valid),
		.resp_op          (resp_op),
		.resp_addr        (resp_addr),
		.resp_hit         (resp_hit),
		.resp_fill_needed (resp_fill_needed),
		.resp_data        (resp_data),
		.wb_valid         (wb_valid),
		.wb_addr          (wb_addr),
		.wb_data          (wb_data)
	);

	function automatic l2_addr_u make_addr(input logic [TAG_BITS-1:0] tag,
		input logic [SET_BITS-1:0] set);
		l2_addr_u a;
		a.parts.tag = tag;
		a.parts.set = set;
		return a;
	endfunction

	function automatic logic [LINE_BITS-1:0] rand_line();
		return {$urandom, $urandom, $urandom, $urandom};
	endfunction

	// Expected response, and the model updated as the cache would be
	function automatic resp_t predict_response(input logic op, input l2_addr_u addr,
		input logic [LINE_BITS-1:0] data, input logic [MASK_BITS-1:0] mask,
		input logic has_fill, input logic [LINE_BITS-1:0] fill);
		resp_t                r;
		int                   set;
		int                   way;
		logic [LINE_BITS-1:0] line;
		logic                 dirty;
		r = '0;
		r.op = op;
		r.addr = addr;
		set = addr.parts.set;
		way = -1;
		for (int w = 0; w < NUM_WAYS; w++)
		begin
			if (m_valid[set][w] && m_tag[set][w] == addr.parts.tag)
				way = w;
		end
		if (way >= 0)
		begin
			r.hit = 1'b1;
			line = m_line[set][way];
			dirty = m_dirty[set][way];
		end
		else if (!has_fill)
		begin
			r.fill_needed = 1'b1;
			return r;
		end
		else
		begin
			way = addr.parts.tag[WAY_BITS-1:0];
			for (int w = NUM_WAYS - 1; w >= 0; w--)
			begin
				if (!m_valid[set][w])
					way = w;
			end
			if (m_valid[set][way] && m_dirty[set][way])
			begin
				r.wb_valid = 1'b1;
				r.wb_addr = make_addr(m_tag[set][way], SET_BITS'(set));
				r.wb_data = m_line[set][way];
			end
			line = fill;
			dirty = 1'b0;
		end
		if (op == OP_STORE)
		begin
			for (int b = 0; b < MASK_BITS; b++)
			begin
				if (mask[b])
					line[b*8 +: 8] = data[b*8 +: 8];
			end
			dirty = 1'b1;
		end
		m_valid[set][way] = 1'b1;
		m_dirty[set][way] = dirty;
		m_tag[set][way] = addr.parts.tag;
		m_line[set][way] = line;
		r.data = line;
		return r;
	endfunction

	task automatic abort_run();
		$display("*** TEST FAILED ***");
		$fatal(1, "Stopping at the first failure");
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("** Error at %0t: %s is %b, expected %b", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_addr(input string name, input l2_addr_u got, input l2_addr_u exp);
		if (got !== exp)
		begin
			$display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_line(input string name, input logic [LINE_BITS-1:0] got,
		input logic [LINE_BITS-1:0] exp);
		if (got !== exp)
		begin
			$display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic idle_cycle();
		@(posedge clk);
		#1;
		req_valid = 1'b0;
		slot++;
	endtask

	task automatic send_req(input logic op, input l2_addr_u addr,
		input logic [LINE_BITS-1:0] data, input logic [MASK_BITS-1:0] mask,
		input logic has_fill, input logic [LINE_BITS-1:0] fill);
		@(posedge clk);
		#1;
		req_valid = 1'b1;
		req_op = op;
		req_addr = addr;
		req_data = data;
		req_mask = mask;
		req_has_fill = has_fill;
		req_fill_data = fill;
		exp_q.push_back(predict_response(op, addr, data, mask, has_fill, fill));
		last_slot[addr.parts.set] = slot;
		slot++;
		sent_count++;
	endtask

	task automatic drain();
		idle_cycle();
		while (exp_q.size() != 0)
			idle_cycle();
	endtask

	task automatic request_and_wait(input logic op, input l2_addr_u addr,
		input logic [LINE_BITS-1:0] data, input logic [MASK_BITS-1:0] mask,
		input logic has_fill, input logic [LINE_BITS-1:0] fill);
		send_req(op, addr, data, mask, has_fill, fill);
		drain();
	endtask

	task automatic run_directed();
		l2_addr_u a;
		a = make_addr(12'h123, 4'h1);
		// Miss without fill, twice, then fill, hit, store merge and reload
		request_and_wait(OP_LOAD, a, '0, '0, 1'b0, '0);
		request_and_wait(OP_LOAD, a, '0, '0, 1'b0, '0);
		request_and_wait(OP_LOAD, a, '0, '0, 1'b1, rand_line());
		request_and_wait(OP_LOAD, a, '0, '0, 1'b0, '0);
		request_and_wait(OP_STORE, a, rand_line(), 16'h00f0, 1'b0, '0);
		request_and_wait(OP_LOAD, a, '0, '0, 1'b0, '0);
		// Tags 010, 021, 032, 043 land in ways 0 to 3 of set 5
		for (int t = 0; t < NUM_WAYS; t++)
			request_and_wait(OP_LOAD, make_addr(TAG_BITS'(12'h010 + t * 12'h011), 4'h5),
				'0, '0, 1'b1, rand_line());
		request_and_wait(OP_STORE, make_addr(12'h021, 4'h5), rand_line(), 16'hff00, 1'b0, '0);
		// Way 1 is dirty and written back, way 2 is clean
		request_and_wait(OP_LOAD, make_addr(12'h105, 4'h5), '0, '0, 1'b1, rand_line());
		request_and_wait(OP_LOAD, make_addr(12'h206, 4'h5), '0, '0, 1'b1, rand_line());
	endtask

	task automatic run_random();
		int set;
		for (int n = 0; n < NUM_RANDOM; n++)
		begin
			if ($urandom_range(0, 3) == 0)
				idle_cycle();
			set = $urandom_range(0, NUM_SETS - 1);
			// Same set only after four cycles
			while (slot - last_slot[set] < 4)
				set = (set + 1) % NUM_SETS;
			send_req(1'($urandom_range(0, 1)),
				make_addr(TAG_BITS'($urandom_range(0, 7)), SET_BITS'(set)),
				rand_line(), MASK_BITS'($urandom), 1'($urandom_range(0, 1)), rand_line());
		end
	endtask

	always @(negedge clk)
	begin
		if (arst_n && resp_valid)
		begin
			if (exp_q.size() == 0)
			begin
				$display("Response at %0t arrived with no request outstanding", $time);
				abort_run();
			end
			else
			begin
				expected = exp_q.pop_front();
				seen_count++;
				check_bit("resp_op", resp_op, expected.op);
				check_addr("resp_addr", resp_addr, expected.addr);
				check_bit("resp_hit", resp_hit, expected.hit);
				check_bit("resp_fill_needed", resp_fill_needed, expected.fill_needed);
				if (!expected.fill_needed)
					check_line("resp_data", resp_data, expected.data);
				check_bit("wb_valid", wb_valid, expected.wb_valid);
				if (expected.wb_valid)
				begin
					check_addr("wb_addr", wb_addr, expected.wb_addr);
					check_line("wb_data", wb_data, expected.wb_data);
				end
			end
		end
		else if (arst_n && wb_valid)
		begin
			$display("Write-back at %0t came without a response", $time);
			abort_run();
		end
	end

	initial
	begin
		#(TIMEOUT);
		$display("Watchdog expired after %0d time units, the run did not finish", TIMEOUT);
		abort_run();
	end

	initial
	begin
		req_valid = 1'b0;
		req_op = OP_LOAD;
		req_addr = '0;
		req_data = '0;
		req_mask = '0;
		req_has_fill = 1'b0;
		req_fill_data = '0;
		void'($urandom(32'hadad));
		for (int s = 0; s < NUM_SETS; s++)
		begin
			last_slot[s] = -100;
			for (int w = 0; w < NUM_WAYS; w++)
			begin
				m_valid[s][w] = 1'b0;
				m_dirty[s][w] = 1'b0;
				m_tag[s][w] = '0;
				m_line[s][w] = '0;
			end
		end
		wait (arst_n === 1'b1);
		repeat (2) @(posedge clk);
		run_directed();
		run_random();
		drain();
		repeat (8) idle_cycle();
		if (seen_count == sent_count && exp_q.size() == 0)
		begin
			$display("*** TEST PASSED ***");
			$finish;
		end
		else
		begin
			$display("Only %0d of %0d responses arrived", seen_count, sent_count);
			$display("*** TEST FAILED ***");
			$fatal(1, "Responses missing at the end of the run");
		end
	end

endmodule

// File: sources.f
src/l2_pkg.sv
src/l2_ifs.sv
src/l2_dir_issue.sv
src/l2_tag_way.sv
src/l2_way_select.sv
src/l2_cache_read.sv
src/l2_cache_write.sv
src/l2_cache_top.sv
bench/tb_clock_gen.sv
bench/tb_l2_cache.sv

// File: src/l2_cache_read.sv
// Data read stage of the L2 pipeline
// Line memory with registered read and fill data bypass

module l2_cache_read (
	input  logic                              clk,
	input  logic                              arst_n,
	l2_stage_if.sink                          in_stage,
	l2_lookup_if.select                       lookup,
	l2_stage_if.source                        out_stage,
	output logic                              rd_hit,
	output logic [l2_pkg::WAY_BITS-1:0]       rd_way,
	output logic                              rd_victim_dirty,
	output logic [l2_pkg::TAG_BITS-1:0]       rd_victim_tag,
	output logic [l2_pkg::LINE_BITS-1:0]      rd_line,
	output logic [l2_pkg::LINE_BITS-1:0]      rd_victim_line,
	input  logic                              mem_wr_en,
	input  logic [l2_pkg::MEM_ADDR_BITS-1:0]  mem_wr_addr,
	input  logic [l2_pkg::LINE_BITS-1:0]      mem_wr_data
);
	import l2_pkg::*;

	logic [LINE_BITS-1:0]     cache_mem [2**MEM_ADDR_BITS];
	logic                     hit;
	logic [WAY_BITS-1:0]      hit_way;
	logic [WAY_BITS-1:0]      replace_way;
	logic [WAY_BITS-1:0]      mem_way;
	logic                     victim_dirty;
	logic [TAG_BITS-1:0]      victim_tag;
	logic [MEM_ADDR_BITS-1:0] mem_addr;
	logic                     use_fill;

	l2_way_select i_way_select (
		.lookup       (lookup),
		.hit          (hit),
		.hit_way      (hit_way),
		.replace_way  (replace_way),
		.victim_dirty (victim_dirty),
		.victim_tag   (victim_tag)
	);

	assign mem_way  = hit ? hit_way : replace_way;
	assign mem_addr = {mem_way, in_stage.addr.parts.set};
	// Fill line replaces the stored one on an allocating miss
	assign use_fill = !hit && in_stage.has_fill;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			out_stage.valid <= 1'b0;
		else
			out_stage.valid <= in_stage.valid;
	end

	always_ff @(posedge clk)
	begin
		out_stage.op        <= in_stage.op;
		out_stage.addr      <= in_stage.addr;
		out_stage.data      <= in_stage.data;
		out_stage.mask      <= in_stage.mask;
		out_stage.has_fill  <= in_stage.has_fill;
		out_stage.fill_data <= in_stage.fill_data;
		rd_hit              <= hit;
		rd_way              <= mem_way;
		rd_victim_dirty     <= victim_dirty;
		rd_victim_tag       <= victim_tag;
		rd_victim_line      <= cache_mem[mem_addr];
		rd_line             <= use_fill ? in_stage.fill_data : cache_mem[mem_addr];
		if (mem_wr_en)
			cache_mem[mem_wr_addr] <= mem_wr_data;
	end

	// Same-set spacing keeps the write stage off the entry being read
	a_no_rw_clash: assert property (@(posedge clk) disable iff (!arst_n)
		!(mem_wr_en && in_stage.valid && mem_wr_addr == mem_addr));

endmodule

// File: src/l2_cache_top.sv
// Top level of the L2 cache request pipeline
// Issue, four tag ways, data read and write stages

module l2_cache_top (
	input  logic                         clk,
	input  logic                         arst_n,
	input  logic                         req_valid,
	input  logic                         req_op,
	input  l2_pkg::l2_addr_u             req_addr,
	input  logic [l2_pkg::LINE_BITS-1:0] req_data,
	input  logic [l2_pkg::MASK_BITS-1:0] req_mask,
	input  logic                         req_has_fill,
	input  logic [l2_pkg::LINE_BITS-1:0] req_fill_data,
	output logic                         resp_valid,
	output logic                         resp_op,
	output l2_pkg::l2_addr_u             resp_addr,
	output logic                         resp_hit,
	output logic                         resp_fill_needed,
	output logic [l2_pkg::LINE_BITS-1:0] resp_data,
	output logic                         wb_valid,
	output l2_pkg::l2_addr_u             wb_addr,
	output logic [l2_pkg::LINE_BITS-1:0] wb_data
);
	l2_stage_if      issue_stage ();
	l2_stage_if      read_stage ();
	l2_lookup_if     lookup ();
	l2_tag_update_if tag_update ();

	logic                             rd_hit;
	logic [l2_pkg::WAY_BITS-1:0]      rd_way;
	logic                             rd_victim_dirty;
	logic [l2_pkg::TAG_BITS-1:0]      rd_victim_tag;
	logic [l2_pkg::LINE_BITS-1:0]     rd_line;
	logic [l2_pkg::LINE_BITS-1:0]     rd_victim_line;
	logic                             mem_wr_en;
	logic [l2_pkg::MEM_ADDR_BITS-1:0] mem_wr_addr;
	logic [l2_pkg::LINE_BITS-1:0]     mem_wr_data;

	l2_dir_issue i_issue (
		.clk           (clk),
		.arst_n        (arst_n),
		.req_valid     (req_valid),
		.req_op        (req_op),
		.req_addr      (req_addr),
		.req_data      (req_data),
		.req_mask      (req_mask),
		.req_has_fill  (req_has_fill),
		.req_fill_data (req_fill_data),
		.stage         (issue_stage),
		.lookup        (lookup)
	);

	for (genvar w = 0; w < l2_pkg::NUM_WAYS; w++)
	begin : g_way
		l2_tag_way #(
			.WAY (w)
		) i_way (
			.clk    (clk),
			.arst_n (arst_n),
			.lookup (lookup),
			.update (tag_update)
		);
	end

	l2_cache_read i_read (
		.clk             (clk),
		.arst_n          (arst_n),
		.in_stage        (issue_stage),
		.lookup          (lookup),
		.out_stage       (read_stage),
		.rd_hit          (rd_hit),
		.rd_way          (rd_way),
		.rd_victim_dirty (rd_victim_dirty),
		.rd_victim_tag   (rd_victim_tag),
		.rd_line         (rd_line),
		.rd_victim_line  (rd_victim_line),
		.mem_wr_en       (mem_wr_en),
		.mem_wr_addr     (mem_wr_addr),
		.mem_wr_data     (mem_wr_data)
	);

	l2_cache_write i_write (
		.clk              (clk),
		.arst_n           (arst_n),
		.in_stage         (read_stage),
		.rd_hit           (rd_hit),
		.rd_way           (rd_way),
		.rd_victim_dirty  (rd_victim_dirty),
		.rd_victim_tag    (rd_victim_tag),
		.rd_line          (rd_line),
		.rd_victim_line   (rd_victim_line),
		.update           (tag_update),
		.mem_wr_en        (mem_wr_en),
		.mem_wr_addr      (mem_wr_addr),
		.mem_wr_data      (mem_wr_data),
		.resp_valid       (resp_valid),
		.resp_op          (resp_op),
		.resp_addr        (resp_addr),
		.resp_hit         (resp_hit),
		.resp_fill_needed (resp_fill_needed),
		.resp_data        (resp_data),
		.wb_valid         (wb_valid),
		.wb_addr          (wb_addr),
		.wb_data          (wb_data)
	);

endmodule

// File: src/l2_cache_write.sv
// Write-back and update stage of the L2 pipeline
// Store merge, tag and data update, response and write-back outputs

module l2_cache_write (
	input  logic                              clk,
	input  logic                              arst_n,
	l2_stage_if.sink                          in_stage,
	input  logic                              rd_hit,
	input  logic [l2_pkg::WAY_BITS-1:0]       rd_way,
	input  logic                              rd_victim_dirty,
	input  logic [l2_pkg::TAG_BITS-1:0]       rd_victim_tag,
	input  logic [l2_pkg::LINE_BITS-1:0]      rd_line,
	input  logic [l2_pkg::LINE_BITS-1:0]      rd_victim_line,
	l2_tag_update_if.write                    update,
	output logic                              mem_wr_en,
	output logic [l2_pkg::MEM_ADDR_BITS-1:0]  mem_wr_addr,
	output logic [l2_pkg::LINE_BITS-1:0]      mem_wr_data,
	output logic                              resp_valid,
	output logic                              resp_op,
	output l2_pkg::l2_addr_u                  resp_addr,
	output logic                              resp_hit,
	output logic                              resp_fill_needed,
	output logic [l2_pkg::LINE_BITS-1:0]      resp_data,
	output logic                              wb_valid,
	output l2_pkg::l2_addr_u                  wb_addr,
	output logic [l2_pkg::LINE_BITS-1:0]      wb_data
);
	import l2_pkg::*;

	logic [LINE_BITS-1:0] merged;
	logic                 fill_needed;
	logic                 do_update;
	logic                 wb_needed;
	l2_addr_u             victim_addr;

	always_comb
	begin
		merged = rd_line;
		if (in_stage.op == OP_STORE)
		begin
			for (int i = 0; i < MASK_BITS; i++)
			begin
				if (in_stage.mask[i])
					merged[i*8 +: 8] = in_stage.data[i*8 +: 8];
			end
		end
	end

	assign fill_needed = !rd_hit && !in_stage.has_fill;
	assign do_update   = in_stage.valid && !fill_needed;
	assign wb_needed   = in_stage.valid && !rd_hit && in_stage.has_fill && rd_victim_dirty;

	// Load hit keeps the old dirty bit, a fill by load starts clean
	assign update.upd_valid = do_update;
	assign update.upd_set   = in_stage.addr.parts.set;
	assign update.upd_way   = rd_way;
	assign update.upd_tag   = in_stage.addr.parts.tag;
	assign update.upd_dirty = (in_stage.op == OP_STORE) || (rd_hit && rd_victim_dirty);

	assign mem_wr_en   = do_update;
	assign mem_wr_addr = {rd_way, in_stage.addr.parts.set};
	assign mem_wr_data = merged;

	assign victim_addr.flat = {rd_victim_tag, in_stage.addr.parts.set};

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			resp_valid <= 1'b0;
			wb_valid   <= 1'b0;
		end
		else
		begin
			resp_valid <= in_stage.valid;
			wb_valid   <= wb_needed;
		end
	end

	always_ff @(posedge clk)
	begin
		resp_op          <= in_stage.op;
		resp_addr        <= in_stage.addr;
		resp_hit         <= rd_hit;
		resp_fill_needed <= fill_needed;
		resp_data        <= fill_needed ? '0 : merged;
		wb_addr          <= victim_addr;
		wb_data          <= rd_victim_line;
	end

	// A written-back victim is never the requested line itself
	a_wb_victim: assert property (@(posedge clk) disable iff (!arst_n)
		wb_valid |-> wb_addr.parts.tag != resp_addr.parts.tag);

endmodule

// File: src/l2_dir_issue.sv
// Issue stage of the L2 pipeline
// Registers the request and drives the tag lookup of all ways

module l2_dir_issue (
	input  logic                         clk,
	input  logic                         arst_n,
	input  logic                         req_valid,
	input  logic                         req_op,
	input  l2_pkg::l2_addr_u             req_addr,
	input  logic [l2_pkg::LINE_BITS-1:0] req_data,
	input  logic [l2_pkg::MASK_BITS-1:0] req_mask,
	input  logic                         req_has_fill,
	input  logic [l2_pkg::LINE_BITS-1:0] req_fill_data,
	l2_stage_if.source                   stage,
	l2_lookup_if.issue                   lookup
);
	import l2_pkg::*;

	logic                 q_valid;
	logic                 q_op;
	l2_addr_u             q_addr;
	logic [LINE_BITS-1:0] q_data;
	logic [MASK_BITS-1:0] q_mask;
	logic                 q_has_fill;
	logic [LINE_BITS-1:0] q_fill_data;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			q_valid     <= 1'b0;
			stage.valid <= 1'b0;
		end
		else
		begin
			q_valid     <= req_valid;
			stage.valid <= q_valid;
		end
	end

	// Second register keeps the request aligned with the way read
	always_ff @(posedge clk)
	begin
		q_op            <= req_op;
		q_addr          <= req_addr;
		q_data          <= req_data;
		q_mask          <= req_mask;
		q_has_fill      <= req_has_fill;
		q_fill_data     <= req_fill_data;
		stage.op        <= q_op;
		stage.addr      <= q_addr;
		stage.data      <= q_data;
		stage.mask      <= q_mask;
		stage.has_fill  <= q_has_fill;
		stage.fill_data <= q_fill_data;
	end

	// Set indexes the way arrays, tag is compared after their read
	assign lookup.set          = q_addr.parts.set;
	assign lookup.tag          = stage.addr.parts.tag;
	assign lookup.lookup_valid = stage.valid;

	// A valid request carries a known load or store code
	a_op_known: assert property (@(posedge clk) disable iff (!arst_n)
		req_valid |-> !$isunknown(req_op));

endmodule

// File: src/l2_ifs.sv
// Request bundle between pipeline stages
// Tag lookup broadcast and per-way results
// Tag entry update from the write stage

interface l2_stage_if;
	import l2_pkg::*;

	logic                 valid;
	logic                 op;
	l2_addr_u             addr;
	logic [LINE_BITS-1:0] data;
	logic [MASK_BITS-1:0] mask;
	logic                 has_fill;
	logic [LINE_BITS-1:0] fill_data;

	modport source (output valid, op, addr, data, mask, has_fill, fill_data);
	modport sink (input valid, op, addr, data, mask, has_fill, fill_data);
endinterface

interface l2_lookup_if;
	import l2_pkg::*;

	logic                lookup_valid;
	logic [SET_BITS-1:0] set;
	logic [TAG_BITS-1:0] tag;
	// One element per way, each driven by its own way instance
	logic [NUM_WAYS-1:0] hit;
	logic [NUM_WAYS-1:0] valid;
	logic [NUM_WAYS-1:0] dirty;
	logic [TAG_BITS-1:0] way_tag [NUM_WAYS];

	modport issue (output lookup_valid, set, tag);
	modport way (input lookup_valid, set, tag, output hit, valid, dirty, way_tag);
	modport select (input tag, hit, valid, dirty, way_tag);
endinterface

interface l2_tag_update_if;
	import l2_pkg::*;

	logic                upd_valid;
	logic [SET_BITS-1:0] upd_set;
	logic [WAY_BITS-1:0] upd_way;
	logic [TAG_BITS-1:0] upd_tag;
	logic                upd_dirty;

	modport write (output upd_valid, upd_set, upd_way, upd_tag, upd_dirty);
	modport way (input upd_valid, upd_set, upd_way, upd_tag, upd_dirty);
endinterface

// File: src/l2_pkg.sv
// Cache geometry and widths of the L2 request pipeline
// Operation codes and the line address union

package l2_pkg;

	localparam int NUM_WAYS      = 4;
	localparam int SET_BITS      = 4;
	localparam int TAG_BITS      = 12;
	localparam int ADDR_BITS     = TAG_BITS + SET_BITS;
	localparam int LINE_BITS     = 128;
	localparam int MASK_BITS     = LINE_BITS / 8;
	localparam int WAY_BITS      = 2;
	// Data memory index is {way, set}
	localparam int MEM_ADDR_BITS = WAY_BITS + SET_BITS;

	localparam logic OP_LOAD  = 1'b0;
	localparam logic OP_STORE = 1'b1;

	// Line address, either flat or split into tag and set
	typedef union packed
	{
		logic [ADDR_BITS-1:0] flat;
		struct packed
		{
			logic [TAG_BITS-1:0] tag;
			logic [SET_BITS-1:0] set;
		} parts;
	} l2_addr_u;

endpackage

// File: src/l2_tag_way.sv
// One way of the L2 tag directory
// Tag, valid and dirty per set, registered read and hit compare

module l2_tag_way #(
	parameter int WAY = 0
) (
	input  logic      clk,
	input  logic      arst_n,
	l2_lookup_if.way  lookup,
	l2_tag_update_if.way update
);
	import l2_pkg::*;

	logic [TAG_BITS-1:0]     tag_arr [2**SET_BITS];
	logic [2**SET_BITS-1:0]  valid_arr;
	logic [2**SET_BITS-1:0]  dirty_arr;
	logic [TAG_BITS-1:0]     tag_q;
	logic                    valid_q;
	logic                    dirty_q;
	logic                    upd_here;

	assign upd_here = update.upd_valid && (update.upd_way == WAY_BITS'(WAY));

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			valid_arr <= '0;
			dirty_arr <= '0;
			valid_q   <= 1'b0;
			dirty_q   <= 1'b0;
		end
		else
		begin
			if (upd_here)
			begin
				valid_arr[update.upd_set] <= 1'b1;
				dirty_arr[update.upd_set] <= update.upd_dirty;
			end
			valid_q <= valid_arr[lookup.set];
			dirty_q <= dirty_arr[lookup.set];
		end
	end

	always_ff @(posedge clk)
	begin
		if (upd_here)
			tag_arr[update.upd_set] <= update.upd_tag;
		tag_q <= tag_arr[lookup.set];
	end

	assign lookup.hit[WAY]     = lookup.lookup_valid && valid_q && (tag_q == lookup.tag);
	assign lookup.valid[WAY]   = valid_q;
	assign lookup.dirty[WAY]   = dirty_q;
	assign lookup.way_tag[WAY] = tag_q;

endmodule

// File: src/l2_way_select.sv
// Way selection after tag lookup
// Hit way, replacement way, victim dirty bit and victim tag

module l2_way_select (
	l2_lookup_if.select                  lookup,
	output logic                         hit,
	output logic [l2_pkg::WAY_BITS-1:0]  hit_way,
	output logic [l2_pkg::WAY_BITS-1:0]  replace_way,
	output logic                         victim_dirty,
	output logic [l2_pkg::TAG_BITS-1:0]  victim_tag
);
	import l2_pkg::*;

	logic [WAY_BITS-1:0] sel_way;

	always_comb
	begin
		hit_way = '0;
		for (int i = 0; i < NUM_WAYS; i++)
		begin
			if (lookup.hit[i])
				hit_way = WAY_BITS'(i);
		end
	end

	// Lowest invalid way, else the low tag bits
	always_comb
	begin
		replace_way = lookup.tag[WAY_BITS-1:0];
		for (int i = NUM_WAYS - 1; i >= 0; i--)
		begin
			if (!lookup.valid[i])
				replace_way = WAY_BITS'(i);
		end
	end

	assign hit     = |lookup.hit;
	assign sel_way = hit ? hit_way : replace_way;

	// On a hit this is the hit line's own dirty state
	assign victim_dirty = lookup.valid[sel_way] && lookup.dirty[sel_way];
	assign victim_tag   = lookup.way_tag[sel_way];

	always_comb
	begin
		a_one_hit: assert final ($onehot0(lookup.hit));
	end

endmodule
